/* vlog.f */
source/mem_pkg.sv
source/access_pkg.sv
source/request_latch.sv
source/byte_sequencer.sv
source/mem_ctrl.sv
source/byte_ram.sv
source/mem_subsys.sv
tests/tb_mem_subsys.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mem_subsys
FILELIST  ?= vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

/* tests/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

    import mem_pkg::*;
    import access_pkg::*;

    localparam int RAM_ADDR_BITS = 12;
    // every test address stays inside this window
    localparam int REGION = 256;
    localparam int TIMEOUT = 60;

    logic         clk;
    logic         rst;
    logic         fetch_req;
    addr_t        fetch_addr;
    logic         fetch_ok;
    word_t        fetch_data;
    logic         ls_req;
    logic         ls_write;
    access_size_t ls_size;
    addr_t        ls_addr;
    word_t        ls_wdata;
    logic         ls_ok;
    word_t        ls_rdata;

    ram_byte_t mirror [REGION];
    int        errors;
    int        checks;
    int        seed_ret;

    mem_subsys #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_mem_subsys (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ok   (fetch_ok),
        .fetch_data (fetch_data),
        .ls_req     (ls_req),
        .ls_write   (ls_write),
        .ls_size    (ls_size),
        .ls_addr    (ls_addr),
        .ls_wdata   (ls_wdata),
        .ls_ok      (ls_ok),
        .ls_rdata   (ls_rdata)
    );

    always #5 clk = ~clk;

    // little-endian, zero-extended view of the mirror
    function automatic word_t expect_data(input addr_t a, input int n);
        word_t w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            w[8*k +: 8] = mirror[(a + k) % REGION];
        end
        return w;
    endfunction

    function automatic ram_byte_t fill_byte(input int a);
        return 8'((a * 37 + 27) ^ (a >> 5));
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // called at the falling edge that drove the request
    task automatic wait_for_ok(input bit want_ls, output int cycles, output bit seen);
        seen = 1'b0;
        cycles = 0;
        @(posedge clk);
        @(negedge clk);
        if (want_ls) begin
            ls_req = 1'b0;
        end else begin
            fetch_req = 1'b0;
        end
        while (!seen && cycles < TIMEOUT) begin
            if (want_ls ? ls_ok : fetch_ok) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic do_store(input addr_t a, input access_size_t sz, input word_t d);
        int cycles;
        bit seen;
        ls_req   = 1'b1;
        ls_write = 1'b1;
        ls_size  = sz;
        ls_addr  = a;
        ls_wdata = d;
        wait_for_ok(1'b1, cycles, seen);
        if (!seen) begin
            errors++;
            $display("timeout: no ls_ok for the store to address %h", a);
        end else begin
            for (int k = 0; k < int'(sz); k++) begin
                mirror[(a + k) % REGION] = d[8*k +: 8];
            end
            check_latency("ls_ok latency after store", cycles, int'(sz));
        end
    endtask

    task automatic do_load(input addr_t a, input access_size_t sz);
        int cycles;
        bit seen;
        ls_req   = 1'b1;
        ls_write = 1'b0;
        ls_size  = sz;
        ls_addr  = a;
        wait_for_ok(1'b1, cycles, seen);
        if (!seen) begin
            errors++;
            $display("timeout: no ls_ok for the load from address %h", a);
        end else begin
            check_word("ls_rdata", ls_rdata, expect_data(a, int'(sz)));
            check_latency("ls_ok latency after load", cycles, int'(sz) + 1);
        end
    endtask

    task automatic do_fetch(input addr_t a);
        int cycles;
        bit seen;
        fetch_req  = 1'b1;
        fetch_addr = a;
        wait_for_ok(1'b0, cycles, seen);
        if (!seen) begin
            errors++;
            $display("timeout: no fetch_ok for the fetch from address %h", a);
        end else begin
            check_word("fetch_data", fetch_data, expect_data(a, 4));
            check_latency("fetch_ok latency", cycles, 5);
        end
    endtask

    // word load/store, plus a fetch raised lag cycles later (0 means same cycle)
    task automatic overlap_fetch(input addr_t fa, input addr_t la, input bit wr,
                                 input word_t d, input int lag);
        int cycles;
        int ls_at;
        int fetch_at;
        cycles   = 0;
        ls_at    = -1;
        fetch_at = -1;
        ls_req   = 1'b1;
        ls_write = wr;
        ls_size  = size_word;
        ls_addr  = la;
        ls_wdata = d;
        if (lag == 0) begin
            fetch_req  = 1'b1;
            fetch_addr = fa;
        end
        while ((ls_at < 0 || fetch_at < 0) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            ls_req    = 1'b0;
            fetch_req = (cycles == lag);
            if (cycles == lag) begin
                fetch_addr = fa;
            end
            if (ls_ok && ls_at < 0) begin
                ls_at = cycles;
            end
            if (fetch_ok && fetch_at < 0) begin
                fetch_at = cycles;
            end
        end
        if (ls_at < 0 || fetch_at < 0) begin
            errors++;
            $display("timeout: overlapping requests did not both complete");
        end else begin
            if (ls_at >= fetch_at) begin
                errors++;
                $display("ls_ok did not arrive before fetch_ok");
            end
            if (wr) begin
                for (int k = 0; k < 4; k++) begin
                    mirror[(la + k) % REGION] = d[8*k +: 8];
                end
            end else begin
                check_word("ls_rdata", ls_rdata, expect_data(la, 4));
            end
            // load/store went first, so the fetch sees a finished store
            check_word("fetch_data", fetch_data, expect_data(fa, 4));
        end
    endtask

    task automatic idle_quiet(input int n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("fetch_ok", fetch_ok, 1'b0);
            check_flag("ls_ok", ls_ok, 1'b0);
        end
    endtask

    task automatic fill_region();
        word_t w;
        for (int a = 0; a < REGION; a += 4) begin
            for (int k = 0; k < 4; k++) begin
                w[8*k +: 8] = fill_byte(a + k);
            end
            do_store(addr_t'(a), size_word, w);
        end
    endtask

    task automatic random_traffic(input int n);
        addr_t        a;
        access_size_t sz;
        int           pick;
        for (int i = 0; i < n; i++) begin
            a    = $urandom % (REGION - 3);
            pick = $urandom % 3;
            case (pick)
                0:       sz = size_byte;
                1:       sz = size_half;
                default: sz = size_word;
            endcase
            if ($urandom % 2) begin
                do_store(a, sz, $urandom);
            end else begin
                do_load(a, sz);
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        ls_req     = 1'b0;
        ls_write   = 1'b0;
        ls_size    = size_byte;
        ls_addr    = '0;
        ls_wdata   = '0;
        errors     = 0;
        checks     = 0;
        seed_ret   = $urandom(32'h63122e19);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        idle_quiet(6);
        fill_region();
        do_fetch(32'h0000_0010);
        do_load(32'h0000_0020, size_word);

        // distinct bytes expose any lane swap
        do_store(32'h0000_0040, size_word, 32'hc3a5_1e97);
        do_fetch(32'h0000_0040);
        do_load(32'h0000_0040, size_word);

        do_store(32'h0000_0050, size_word, 32'h1122_3344);
        do_store(32'h0000_0051, size_byte, 32'h0000_00ee);
        do_store(32'h0000_0052, size_half, 32'h0000_a5b6);
        do_load(32'h0000_0050, size_word);
        do_store(32'h0000_0053, size_byte, 32'hffff_ff7c);
        do_load(32'h0000_0050, size_word);

        do_store(32'h0000_0060, size_word, 32'h80f1_7f9c);
        do_load(32'h0000_0060, size_byte);
        do_load(32'h0000_0061, size_byte);
        do_load(32'h0000_0062, size_half);
        do_load(32'h0000_0061, size_half);
        do_load(32'h0000_0063, size_byte);

        overlap_fetch(32'h0000_0070, 32'h0000_0070, 1'b1, 32'h1357_2468, 0);
        overlap_fetch(32'h0000_0040, 32'h0000_0070, 1'b0, '0, 0);
        overlap_fetch(32'h0000_0074, 32'h0000_0074, 1'b1, 32'hdead_beef, 2);

        random_traffic(200);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* source/mem_subsys.sv */
`timescale 1ns/1ps

module mem_subsys #(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_req,
    input  mem_pkg::addr_t           fetch_addr,
    output logic                     fetch_ok,
    output mem_pkg::word_t           fetch_data,
    input  logic                     ls_req,
    input  logic                     ls_write,
    input  access_pkg::access_size_t ls_size,
    input  mem_pkg::addr_t           ls_addr,
    input  mem_pkg::word_t           ls_wdata,
    output logic                     ls_ok,
    output mem_pkg::word_t           ls_rdata
);

    import mem_pkg::*;
    import access_pkg::*;

    logic                     ram_en;
    ram_op_t                  ram_op;
    logic [RAM_ADDR_BITS-1:0] ram_addr;
    ram_byte_t                ram_wdata;
    ram_byte_t                ram_rdata;

    mem_ctrl #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_mem_ctrl (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ok   (fetch_ok),
        .fetch_data (fetch_data),
        .ls_req     (ls_req),
        .ls_write   (ls_write),
        .ls_size    (ls_size),
        .ls_addr    (ls_addr),
        .ls_wdata   (ls_wdata),
        .ls_ok      (ls_ok),
        .ls_rdata   (ls_rdata),
        .ram_en     (ram_en),
        .ram_op     (ram_op),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    byte_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_byte_ram (
        .clk   (clk),
        .en    (ram_en),
        .op    (ram_op),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* source/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram #(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic                     clk,
    input  logic                     en,
    input  access_pkg::ram_op_t      op,
    input  logic [RAM_ADDR_BITS-1:0] addr,
    input  mem_pkg::ram_byte_t       wdata,
    output mem_pkg::ram_byte_t       rdata
);

    import mem_pkg::*;
    import access_pkg::*;

    ram_byte_t mem [2**RAM_ADDR_BITS];

    // read data shows up one clock after the address
    always_ff @(posedge clk) begin
        if (en) begin
            if (op == ram_write) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* source/mem_ctrl.sv */
`timescale 1ns/1ps

module mem_ctrl #(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_req,
    input  mem_pkg::addr_t           fetch_addr,
    output logic                     fetch_ok,
    output mem_pkg::word_t           fetch_data,
    input  logic                     ls_req,
    input  logic                     ls_write,
    input  access_pkg::access_size_t ls_size,
    input  mem_pkg::addr_t           ls_addr,
    input  mem_pkg::word_t           ls_wdata,
    output logic                     ls_ok,
    output mem_pkg::word_t           ls_rdata,
    output logic                     ram_en,
    output access_pkg::ram_op_t      ram_op,
    output logic [RAM_ADDR_BITS-1:0] ram_addr,
    output mem_pkg::ram_byte_t       ram_wdata,
    input  mem_pkg::ram_byte_t       ram_rdata
);

    import mem_pkg::*;
    import access_pkg::*;

    logic         fetch_pending;
    logic         ls_pending;
    addr_t        fetch_held;
    ls_req_t      ls_held;
    ls_req_t      ls_live;
    ls_req_t      ls_cur;
    addr_t        fetch_cur;
    logic         ls_avail;
    logic         fetch_avail;
    logic         ls_grant;
    logic         fetch_grant;
    logic         seq_start;
    ram_op_t      seq_op;
    access_size_t seq_count;
    addr_t        seq_addr;
    logic         seq_busy;
    logic         seq_done;
    word_t        seq_rdata;
    logic         owner_ls;
    word_t        fetch_data_q;
    word_t        ls_rdata_q;

    assign ls_live = '{write: ls_write, size: ls_size, addr: ls_addr, wdata: ls_wdata};

    // latched request first, otherwise the one arriving now
    assign ls_cur      = ls_pending ? ls_held : ls_live;
    assign fetch_cur   = fetch_pending ? fetch_held : fetch_addr;
    assign ls_avail    = ls_pending || ls_req;
    assign fetch_avail = fetch_pending || fetch_req;

    // load/store wins a tie
    assign ls_grant    = !seq_busy && ls_avail;
    assign fetch_grant = !seq_busy && !ls_avail && fetch_avail;
    assign seq_start   = ls_grant || fetch_grant;

    assign seq_op    = (ls_avail && ls_cur.write) ? ram_write : ram_read;
    assign seq_count = ls_avail ? ls_cur.size : size_word;
    assign seq_addr  = ls_avail ? ls_cur.addr : fetch_cur;

    request_latch #(.payload_t(addr_t)) u_fetch_latch (
        .clk       (clk),
        .rst       (rst),
        .load      (fetch_req && !(fetch_grant && !fetch_pending)),
        .load_data (fetch_addr),
        .clear     (fetch_grant),
        .pending   (fetch_pending),
        .held      (fetch_held)
    );

    request_latch #(.payload_t(ls_req_t)) u_ls_latch (
        .clk       (clk),
        .rst       (rst),
        .load      (ls_req && !(ls_grant && !ls_pending)),
        .load_data (ls_live),
        .clear     (ls_grant),
        .pending   (ls_pending),
        .held      (ls_held)
    );

    byte_sequencer #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_byte_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (seq_start),
        .op        (seq_op),
        .count     (seq_count),
        .addr      (seq_addr),
        .wdata     (ls_cur.wdata),
        .busy      (seq_busy),
        .done      (seq_done),
        .rdata     (seq_rdata),
        .ram_en    (ram_en),
        .ram_op    (ram_op),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_ls <= 1'b0;
        end else if (seq_start) begin
            owner_ls <= ls_grant;
        end
    end

    // sequencer clears its word on the next start, so keep a copy
    always_ff @(posedge clk) begin
        if (fetch_ok) begin
            fetch_data_q <= seq_rdata;
        end
        if (ls_ok) begin
            ls_rdata_q <= seq_rdata;
        end
    end

    assign fetch_ok   = seq_done && !owner_ls;
    assign ls_ok      = seq_done && owner_ls;
    assign fetch_data = fetch_ok ? seq_rdata : fetch_data_q;
    assign ls_rdata   = ls_ok ? seq_rdata : ls_rdata_q;

endmodule

/* source/byte_sequencer.sv */
`timescale 1ns/1ps

module byte_sequencer #(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  access_pkg::ram_op_t        op,
    input  access_pkg::access_size_t   count,
    input  mem_pkg::addr_t             addr,
    input  mem_pkg::word_t             wdata,
    output logic                       busy,
    output logic                       done,
    output mem_pkg::word_t             rdata,
    output logic                       ram_en,
    output access_pkg::ram_op_t        ram_op,
    output logic [RAM_ADDR_BITS-1:0]   ram_addr,
    output mem_pkg::ram_byte_t         ram_wdata,
    input  mem_pkg::ram_byte_t         ram_rdata
);

    import mem_pkg::*;
    import access_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write
    } state_t;

    state_t                   state;
    logic [1:0]               idx;
    logic [1:0]               stop;
    logic [1:0]               rd_idx;
    logic                     rd_pend;
    logic [RAM_ADDR_BITS-1:0] run_addr;
    word_t                    wbuf;
    word_t                    rbuf;
    logic                     launch;
    logic                     advance;
    logic                     capture;

    assign busy    = (state != st_idle);
    assign launch  = (state == st_idle) && start;
    // more bytes to put on the RAM port
    assign advance = (state != st_idle) && (idx != stop);
    // RAM answered the read issued two edges back
    assign capture = (state == st_read) && rd_pend;
    assign rdata   = rbuf;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            ram_en  <= 1'b0;
            done    <= 1'b0;
            idx     <= 2'd0;
            rd_idx  <= 2'd0;
            rd_pend <= 1'b0;
        end else begin
            done    <= 1'b0;
            rd_pend <= ram_en && (ram_op == ram_read);
            case (state)
                st_idle: begin
                    if (start) begin
                        state  <= (op == ram_write) ? st_write : st_read;
                        ram_en <= 1'b1;
                        idx    <= 2'd0;
                        rd_idx <= 2'd0;
                    end
                end
                st_write: begin
                    if (advance) begin
                        idx <= idx + 2'd1;
                    end else begin
                        // last byte lands on this edge
                        ram_en <= 1'b0;
                        done   <= 1'b1;
                        state  <= st_idle;
                    end
                end
                st_read: begin
                    if (advance) begin
                        idx <= idx + 2'd1;
                    end else begin
                        ram_en <= 1'b0;
                    end
                    if (capture) begin
                        rd_idx <= rd_idx + 2'd1;
                        if (rd_idx == stop) begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            ram_op    <= op;
            ram_addr  <= addr[RAM_ADDR_BITS-1:0];
            run_addr  <= addr[RAM_ADDR_BITS-1:0] + 1'b1;
            ram_wdata <= wdata[7:0];
            wbuf      <= wdata >> 8;
            stop      <= 2'(count - 1);
            rbuf      <= '0;
        end else begin
            if (advance) begin
                ram_addr  <= run_addr;
                run_addr  <= run_addr + 1'b1;
                ram_wdata <= wbuf[7:0];
                wbuf      <= wbuf >> 8;
            end
            // little-endian lane fill
            if (capture) begin
                rbuf[{rd_idx, 3'b000} +: 8] <= ram_rdata;
            end
        end
    end

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    ) else $error("byte_sequencer: start while an access is running");

    a_count_legal: assert property (
        @(posedge clk) disable iff (rst)
        start |-> (count inside {size_byte, size_half, size_word})
    ) else $error("byte_sequencer: illegal byte count %0d", count);

endmodule

/* source/request_latch.sv */
`timescale 1ns/1ps

module request_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  payload_t load_data,
    input  logic     clear,
    output logic     pending,
    output payload_t held
);

    // a new request beats the clear of the one being granted
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (load) begin
            pending <= 1'b1;
        end else if (clear) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held <= load_data;
        end
    end

    // client must wait for its ok before asking again
    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst)
        load |-> (!pending || clear)
    ) else $error("request_latch: new request while one is still pending");

endmodule

/* source/access_pkg.sv */
package access_pkg;

    // byte count of one access
    typedef enum logic [2:0] {
        size_byte = 3'd1,
        size_half = 3'd2,
        size_word = 3'd4
    } access_size_t;

    typedef enum logic {
        ram_read  = 1'b0,
        ram_write = 1'b1
    } ram_op_t;

    // one load/store request as captured from the client
    typedef struct packed {
        logic           write;
        access_size_t   size;
        mem_pkg::addr_t addr;
        mem_pkg::word_t wdata;
    } ls_req_t;

endpackage

/* source/mem_pkg.sv */
package mem_pkg;

    // client side widths
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;

    // byte address as seen by the fetcher and the load/store unit
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // full client data word, little-endian byte lanes
    typedef logic [WORD_WIDTH-1:0] word_t;

    // one byte on the RAM data port
    typedef logic [7:0] ram_byte_t;

endpackage
